/* logic/pwm_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PWM slave package: counter width, register
// map enum and AHB-Lite transfer codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package pwm_pkg;

    // Counter, period and duty width
    localparam int pwm_width = 8;

    // High address bits 7..4 must be zero to hit the map
    localparam int pwm_map_bits = 4;

    // HTRANS encodings
    localparam logic [1:0] ahb_htrans_idle = 2'b00;   // No transfer
    localparam logic [1:0] ahb_htrans_busy = 2'b01;   // Master stall, no data

    // HRESP encoding
    localparam logic [1:0] ahb_hresp_okay = 2'b00;    // Only response used

    // Word index from haddr[3:2]
    typedef enum logic [1:0] {
        reg_ctrl   = 2'd0,    // Bit 0 is enable
        reg_period = 2'd1,    // Last count value of a period
        reg_duty   = 2'd2,    // High cycles per period
        reg_count  = 2'd3     // Live counter, read only
    } pwm_reg_e;

endpackage : pwm_pkg

`default_nettype wire

/* logic/pwm_ahb_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite address phase capture, write
// strobe and HREADYOUT for the PWM slave
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pwm_ahb_decode
    import pwm_pkg::*;
(
    input  logic        hclk,       // Bus clock
    input  logic        rst_n,      // Sync reset, active low
    input  logic        hsel_s,     // Slave select
    input  logic [1:0]  htrans_s,   // Transfer type
    input  logic        hwrite_s,   // Write when high
    input  logic [31:0] haddr_s,    // Byte address
    output pwm_reg_e    reg_sel,    // Registered word index
    output logic        map_hit,    // Registered map hit
    output logic        wr_en,      // Data phase write pulse
    output logic        hready_s    // High in data phase
);

    logic trans_req;    // Address phase of any transfer
    logic data_req;     // Address phase that carries data
    logic addr_hit;     // Upper map bits clear

    // Request whenever selected and not IDLE
    assign trans_req = hsel_s && (htrans_s != ahb_htrans_idle);

    // BUSY gets its OKAY beat but moves no data
    assign data_req = trans_req && (htrans_s != ahb_htrans_busy);

    assign addr_hit = (haddr_s[4 +: pwm_map_bits] == '0);   // Bits 7..4

    // Address phase capture
    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            reg_sel <= reg_ctrl;
            map_hit <= 1'b0;
        end else if (data_req) begin
            reg_sel <= pwm_reg_e'(haddr_s[3:2]);    // Word index, byte lanes ignored
            map_hit <= addr_hit;
        end
    end

    // Strobes for the data phase
    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            wr_en    <= 1'b0;
            hready_s <= 1'b0;
        end else begin
            wr_en    <= data_req && hwrite_s;   // One cycle per write
            hready_s <= trans_req;              // No wait states
        end
    end

endmodule : pwm_ahb_decode

`default_nettype wire

/* logic/pwm_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PWM control, period and duty registers,
// shadow copies and read-back mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pwm_regs
    import pwm_pkg::*;
(
    input  logic                 hclk,         // Bus clock
    input  logic                 rst_n,        // Sync reset, active low
    input  pwm_reg_e             reg_sel,      // Word index from decode
    input  logic                 map_hit,      // Access inside the map
    input  logic                 wr_en,        // Data phase write pulse
    input  logic [31:0]          hwdata_s,     // Write data, data phase
    input  logic                 period_end,   // Counter wraps this cycle
    input  logic [pwm_width-1:0] count,        // Live counter value
    output logic [31:0]          hrdata_s,     // Read data, data phase
    output logic                 enable,       // Control bit 0
    output logic [pwm_width-1:0] period_act,   // Period in use
    output logic [pwm_width-1:0] duty_act      // Duty in use
);

    logic [pwm_width-1:0] period_reg;   // Programmed period
    logic [pwm_width-1:0] duty_reg;     // Programmed duty
    logic                 reg_wr;       // Write that hits the map
    logic                 shadow_ld;    // Take new period and duty
    logic [31:0]          rd_word;      // Selected register, zero extended

    assign reg_wr = wr_en && map_hit;

    // Programmed registers, written at the end of the data phase
    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            enable     <= 1'b0;
            period_reg <= '0;
            duty_reg   <= '0;
        end else if (reg_wr) begin
            case (reg_sel)
                reg_ctrl:   enable     <= hwdata_s[0];
                reg_period: period_reg <= hwdata_s[pwm_width-1:0];
                reg_duty:   duty_reg   <= hwdata_s[pwm_width-1:0];
                default:    ;                                   // reg_count is read only
            endcase
        end
    end

    // Shadows move only between periods.
    // While stopped they simply follow the programmed values, so
    // the first period after enable already uses them.
    assign shadow_ld = period_end || !enable;

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            period_act <= '0;
            duty_act   <= '0;
        end else if (shadow_ld) begin
            period_act <= period_reg;
            duty_act   <= duty_reg;
        end
    end

    // Read-back from the registered select
    always_comb begin
        rd_word = '0;
        case (reg_sel)
            reg_ctrl:   rd_word[0]             = enable;
            reg_period: rd_word[pwm_width-1:0] = period_reg;
            reg_duty:   rd_word[pwm_width-1:0] = duty_reg;
            reg_count:  rd_word[pwm_width-1:0] = count;     // Zero while stopped
            default:    rd_word = '0;
        endcase
    end

    assign hrdata_s = map_hit ? rd_word : '0;   // Outside the map reads zero

endmodule : pwm_regs

`default_nettype wire

/* logic/pwm_counter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PWM period counter, duty compare and
// period-end pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pwm_counter
    import pwm_pkg::*;
(
    input  logic                 hclk,         // Bus clock
    input  logic                 rst_n,        // Sync reset, active low
    input  logic                 enable,       // Run the counter
    input  logic [pwm_width-1:0] period_act,   // Last count of a period
    input  logic [pwm_width-1:0] duty_act,     // High cycles per period
    output logic [pwm_width-1:0] count,        // Position in the period
    output logic                 period_end,   // Wrap this cycle
    output logic                 pwm           // Output pin
);

    logic at_top;       // Count reached period_act
    logic duty_high;    // Compare result for this count

    assign at_top = (count == period_act);

    // Wrap pulse, also the shadow load for the next period
    assign period_end = enable && at_top;

    // 0 .. period_act, then back to 0
    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!enable) begin
            count <= '0;                        // Parked at the start
        end else if (at_top) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Duty wider than the period keeps the pin high all period
    assign duty_high = enable && (count < duty_act);

    // Registered compare, one cycle behind count
    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            pwm <= 1'b0;
        end else begin
            pwm <= duty_high;
        end
    end

endmodule : pwm_counter

`default_nettype wire

/* logic/pwm_ahb_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite PWM slave top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pwm_ahb_top
    import pwm_pkg::*;
(
    input  logic        hclk,       // Bus clock, also PWM clock
    input  logic        rst_n,      // Sync reset, active low
    input  logic [31:0] haddr_s,    // HADDR
    input  logic [31:0] hwdata_s,   // HWDATA
    input  logic        hwrite_s,   // HWRITE
    input  logic [1:0]  htrans_s,   // HTRANS
    input  logic [2:0]  hsize_s,    // HSIZE, word access assumed
    input  logic [2:0]  hburst_s,   // HBURST, single beats only
    input  logic        hsel_s,     // HSEL
    output logic [31:0] hrdata_s,   // HRDATA
    output logic [1:0]  hresp_s,    // HRESP
    output logic        hready_s,   // HREADYOUT
    output logic        pwm         // PWM pin
);

    pwm_reg_e             reg_sel;
    logic                 map_hit;
    logic                 wr_en;
    logic                 enable;
    logic [pwm_width-1:0] period_act;
    logic [pwm_width-1:0] duty_act;
    logic [pwm_width-1:0] count;
    logic                 period_end;

    assign hresp_s = ahb_hresp_okay;    // Never errors

    pwm_ahb_decode u_decode (
        .hclk       (hclk),
        .rst_n      (rst_n),
        .hsel_s     (hsel_s),
        .htrans_s   (htrans_s),
        .hwrite_s   (hwrite_s),
        .haddr_s    (haddr_s),
        .reg_sel    (reg_sel),
        .map_hit    (map_hit),
        .wr_en      (wr_en),
        .hready_s   (hready_s)
    );

    pwm_regs u_regs (
        .hclk       (hclk),
        .rst_n      (rst_n),
        .reg_sel    (reg_sel),
        .map_hit    (map_hit),
        .wr_en      (wr_en),
        .hwdata_s   (hwdata_s),     // Straight from the bus in data phase
        .period_end (period_end),
        .count      (count),
        .hrdata_s   (hrdata_s),
        .enable     (enable),
        .period_act (period_act),
        .duty_act   (duty_act)
    );

    pwm_counter u_counter (
        .hclk       (hclk),
        .rst_n      (rst_n),
        .enable     (enable),
        .period_act (period_act),
        .duty_act   (duty_act),
        .count      (count),
        .period_end (period_end),
        .pwm        (pwm)
    );

endmodule : pwm_ahb_top

`default_nettype wire

/* tb/pwm_ahb_sva.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound checks on AHB decode strobes and
// the PWM counter outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pwm_ahb_sva
    import pwm_pkg::*;
(
    input logic       hclk,         // Bus clock
    input logic       rst_n,        // Sync reset, active low
    input logic       hsel_s,       // Slave select
    input logic [1:0] htrans_s,     // Transfer type
    input logic       hready_s,     // HREADYOUT
    input logic       wr_en,        // Decode write pulse
    input logic       period_end,   // Counter wrap pulse
    input logic       enable,       // Control bit 0
    input logic       pwm           // Output pin
);

    logic trans_req;    // Address phase of a transfer

    assign trans_req = hsel_s && (htrans_s != ahb_htrans_idle);

    // Ready one cycle after a request
    ready_after_req: assert property (@(posedge hclk) disable iff (!rst_n)
        trans_req |=> hready_s)
        else $error("hready_s low in the cycle after a transfer request");

    // And only then
    ready_only_after_req: assert property (@(posedge hclk) disable iff (!rst_n)
        !trans_req |=> !hready_s)
        else $error("hready_s high without a request in the previous cycle");

    write_in_data_phase: assert property (@(posedge hclk) disable iff (!rst_n)
        wr_en |-> hready_s)
        else $error("wr_en high outside a data phase");

    // Wrap lasts a single cycle
    period_end_single: assert property (@(posedge hclk) disable iff (!rst_n)
        period_end |=> !period_end)
        else $error("period_end high for two cycles in a row");

    pwm_off_when_disabled: assert property (@(posedge hclk) disable iff (!rst_n)
        !enable |=> !pwm)
        else $error("pwm high one cycle after enable was low");

endmodule : pwm_ahb_sva

`default_nettype wire

/* tb/pwm_ahb_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the AHB-Lite PWM slave: file
// driven bus accesses, read checks, PWM duty
// measurement and a cycle watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pwm_ahb_tb
    import pwm_pkg::*;
();

    localparam string       stim_file     = "tb/pwm_stimulus.txt";
    localparam int          stim_lines    = 64;             // Max commands in the file
    localparam int          reset_cycles  = 5;
    localparam int          reset_budget  = 16;             // Reset plus drain cycles
    localparam logic [1:0]  htrans_nonseq = 2'b10;
    localparam logic [31:0] period_addr   = 32'h0000_0004;
    localparam logic [31:0] count_addr    = 32'h0000_000c;
    localparam logic [31:0] op_end        = 32'd0;
    localparam logic [31:0] op_write      = 32'd1;
    localparam logic [31:0] op_read       = 32'd2;
    localparam logic [31:0] op_measure    = 32'd3;
    localparam logic [31:0] op_wait       = 32'd4;

    logic        hclk;
    logic        rst_n;
    logic [31:0] haddr_s;
    logic [31:0] hwdata_s;
    logic        hwrite_s;
    logic [1:0]  htrans_s;
    logic [2:0]  hsize_s;
    logic [2:0]  hburst_s;
    logic        hsel_s;
    logic [31:0] hrdata_s;
    logic [1:0]  hresp_s;
    logic        hready_s;
    logic        pwm;

    logic [31:0] stim_mem [0:4*stim_lines-1];   // op, addr, data, expected per command
    int          cycle_cnt      = 0;
    int          timeout_cycles = 0;            // Zero until the file is loaded

    pwm_ahb_top dut0 (
        .hclk     (hclk),
        .rst_n    (rst_n),
        .haddr_s  (haddr_s),
        .hwdata_s (hwdata_s),
        .hwrite_s (hwrite_s),
        .htrans_s (htrans_s),
        .hsize_s  (hsize_s),
        .hburst_s (hburst_s),
        .hsel_s   (hsel_s),
        .hrdata_s (hrdata_s),
        .hresp_s  (hresp_s),
        .hready_s (hready_s),
        .pwm      (pwm)
    );

    bind pwm_ahb_top pwm_ahb_sva u_sva (
        .hclk       (hclk),
        .rst_n      (rst_n),
        .hsel_s     (hsel_s),
        .htrans_s   (htrans_s),
        .hready_s   (hready_s),
        .wr_en      (wr_en),
        .period_end (period_end),
        .enable     (enable),
        .pwm        (pwm)
    );

    initial begin
        hclk = 1'b0;
        forever #50 hclk = ~hclk;   // 100 ns period
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Cycles each command may take, summed over the file
    function automatic int stimulus_budget();
        int          total;
        int          c;
        logic [31:0] op;
        total = 0;
        for (c = 0; c < stim_lines; c++) begin
            op = stim_mem[4*c];
            if (op == op_write || op == op_read) begin
                total += 2;
            end else if (op == op_wait) begin
                total += int'(stim_mem[4*c+2]);
            end else if (op == op_measure) begin
                total += 4 * (int'(stim_mem[4*c+2]) + 1) + 8;   // Settle, poll, window
            end
        end
        return total;
    endfunction

    // Index of the first command with an unknown op, -1 if none
    function automatic int first_bad_line();
        int c;
        int bad;
        bit ended;
        bad   = -1;
        ended = 1'b0;
        for (c = 0; c < stim_lines; c++) begin
            if (stim_mem[4*c] == op_end) begin
                ended = 1'b1;
            end else if (!ended && bad < 0 && stim_mem[4*c] > op_wait) begin
                bad = c;
            end
        end
        return bad;
    endfunction

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input string name);
        @(posedge hclk);                // Address phase
        hsel_s   <= 1'b1;
        htrans_s <= htrans_nonseq;
        hwrite_s <= 1'b1;
        haddr_s  <= addr;
        @(posedge hclk);                // Data phase
        hsel_s   <= 1'b0;
        htrans_s <= ahb_htrans_idle;
        hwrite_s <= 1'b0;
        hwdata_s <= data;
        @(negedge hclk);
        check_value({name, " hready"}, 32'd1, {31'd0, hready_s});
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                            input string name);
        @(posedge hclk);
        hsel_s   <= 1'b1;
        htrans_s <= htrans_nonseq;
        hwrite_s <= 1'b0;
        haddr_s  <= addr;
        @(posedge hclk);
        hsel_s   <= 1'b0;
        htrans_s <= ahb_htrans_idle;
        @(negedge hclk);                // Read data settled mid data phase
        check_value({name, " hready"}, 32'd1, {31'd0, hready_s});
        check_value({name, " hresp"}, {30'd0, ahb_hresp_okay}, {30'd0, hresp_s});
        data = hrdata_s;
    endtask

    // High cycles over one period that starts at a counter wrap
    task automatic measure_high(input logic [31:0] period_exp, input logic [31:0] high_exp,
                                input string name);
        logic [31:0] period_rd;
        int          period_cyc;
        int          high_cnt;
        int          i;
        bit          found;
        period_cyc = int'(period_exp) + 1;
        bus_read(period_addr, period_rd, name);
        check_value({name, " period"}, period_exp, period_rd);
        repeat (2 * period_cyc) @(posedge hclk);    // Two full periods to settle shadows
        @(posedge hclk);
        hsel_s   <= 1'b1;
        htrans_s <= htrans_nonseq;
        hwrite_s <= 1'b0;
        haddr_s  <= count_addr;
        found = 1'b0;
        for (i = 0; i <= period_cyc && !found; i++) begin
            @(posedge hclk);                        // Back to back count reads
            @(negedge hclk);
            if (hready_s && hrdata_s == '0) begin
                found = 1'b1;
            end
        end
        check_value({name, " wrap seen"}, 32'd1, {31'd0, found});
        high_cnt = 0;
        for (i = 0; i < period_cyc; i++) begin
            @(posedge hclk);
            if (i == 0) begin
                hsel_s   <= 1'b0;
                htrans_s <= ahb_htrans_idle;
            end
            @(negedge hclk);
            if (pwm) begin
                high_cnt++;                         // pwm lags count by one cycle
            end
        end
        check_value({name, " high count"}, high_exp, high_cnt);
    endtask

    initial begin : watchdog
        while (timeout_cycles == 0 || cycle_cnt < timeout_cycles) begin
            @(posedge hclk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the stimulus did not complete", cycle_cnt);
        $display(">>> FAIL");
        $fatal(1, "timeout");
    end

    initial begin : stimulus
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
        logic [31:0] rd_data;
        int          cmd;
        int          k;
        int          bad_line;
        string       name;
        rst_n    = 1'b0;
        hsel_s   = 1'b0;
        htrans_s = ahb_htrans_idle;
        hwrite_s = 1'b0;
        haddr_s  = '0;
        hwdata_s = '0;
        hsize_s  = 3'b010;              // Word
        hburst_s = 3'b000;              // Single
        for (k = 0; k < 4*stim_lines; k++) begin
            stim_mem[k] = '0;           // Unused tail reads as end
        end
        $readmemh(stim_file, stim_mem);
        bad_line = first_bad_line();
        if (stim_mem[0] == op_end) begin
            $display("stimulus file %s holds no commands", stim_file);
            $display(">>> FAIL");
            $fatal(1, "empty stimulus file");
        end else if (bad_line >= 0) begin
            $display("stimulus command %0d holds an unknown operation", bad_line);
            $display(">>> FAIL");
            $fatal(1, "bad stimulus file");
        end else begin
            timeout_cycles = 2 * (reset_budget + stimulus_budget());
            repeat (reset_cycles) @(posedge hclk);
            rst_n <= 1'b1;
            cmd = 0;
            while (cmd < stim_lines && stim_mem[4*cmd] != op_end) begin
                op       = stim_mem[4*cmd];
                addr     = stim_mem[4*cmd+1];
                data     = stim_mem[4*cmd+2];
                expected = stim_mem[4*cmd+3];
                name     = $sformatf("cmd %0d op %0d addr 0x%02h", cmd, op, addr[7:0]);
                case (op)
                    op_write:   bus_write(addr, data, name);
                    op_read: begin
                        bus_read(addr, rd_data, name);
                        check_value(name, expected, rd_data);
                    end
                    op_measure: measure_high(data, expected, name);
                    op_wait:    repeat (int'(data)) @(posedge hclk);
                    default:    ;
                endcase
                cmd++;
            end
            repeat (2) @(posedge hclk);
            $display(">>> PASS");
            $finish;
        end
    end

endmodule : pwm_ahb_tb

`default_nettype wire

/* tb/pwm_stimulus.txt */
// op addr data expected, all hex. op 1 write, 2 read, 3 measure, 4 wait, 0 end
// measure: data is the programmed period, expected is the pwm high count per period
4 00000000 00000004 00000000
2 00000000 00000000 00000000
2 00000004 00000000 00000000
2 00000008 00000000 00000000
2 0000000c 00000000 00000000
3 00000000 00000000 00000000
1 00000004 123456a5 00000000
2 00000004 00000000 000000a5
1 00000008 ffffff3c 00000000
2 00000008 00000000 0000003c
1 00000000 fffffffe 00000000
2 00000000 00000000 00000000
1 00000000 ffffffff 00000000
2 00000000 00000000 00000001
1 00000000 00000000 00000000
1 0000000c 00000055 00000000
2 0000000c 00000000 00000000
1 00000014 00000077 00000000
2 00000004 00000000 000000a5
2 00000018 00000000 00000000
1 00000010 00000001 00000000
2 00000000 00000000 00000000
1 00000004 00000009 00000000
1 00000008 00000003 00000000
1 00000000 00000001 00000000
3 00000000 00000009 00000003
1 00000008 0000000a 00000000
3 00000000 00000009 0000000a
1 00000004 00000004 00000000
1 00000008 00000002 00000000
3 00000000 00000004 00000002
1 00000004 0000000f 00000000
1 00000008 00000007 00000000
3 00000000 0000000f 00000007
1 00000008 00000000 00000000
3 00000000 0000000f 00000000
1 00000004 00000009 00000000
1 00000008 00000014 00000000
3 00000000 00000009 0000000a
1 00000000 00000000 00000000
2 0000000c 00000000 00000000
3 00000000 00000009 00000000
0 00000000 00000000 00000000

/* sim.f */
logic/pwm_pkg.sv
logic/pwm_ahb_decode.sv
logic/pwm_regs.sv
logic/pwm_counter.sv
logic/pwm_ahb_top.sv
tb/pwm_ahb_sva.sv
tb/pwm_ahb_tb.sv

/* Makefile */
# Verilator build and run for the AHB-Lite PWM slave

VERILATOR ?= verilator
TOP       ?= pwm_ahb_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

# Exit status of the simulation is the test result
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
